// File: files.f
rtl/dcachePkg.sv
rtl/dcacheArray.sv
rtl/dcacheController.sv
rtl/dataCache.sv
verification/tbClock.sv
verification/memoryModel.sv
verification/dataCacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the dataCache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing -j 0 --top-module dataCacheTb -f files.f -o simDataCache \
    && ./obj_dir/simDataCache 2>&1 | tee sim.log \
    && grep -q "Everything OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verification/dataCacheTb.sv
// stimulus, shadow memory, residency model, checking assertions and timeout
`default_nettype none

module dataCacheTb;

    // 305 accesses at about 45 cycles worst case plus margin
    localparam int numRandom = 300;
    localparam int cycleLimit = 20000;

    logic clock;
    logic reset;
    dcachePkg::cpuRequest cpuReq;
    logic [31:0] rdata;
    logic stall;
    logic memReq;
    dcachePkg::memCommand memCmd;
    logic memAck;
    dcachePkg::cacheLine memRdata;

    integer seed;
    int cycles = 0;
    logic started;
    logic accepted;

    // architectural memory where bytes never stored read back the preload pattern
    logic [7:0] shadow [65536];
    logic [65535:0] written;

    // block each set should hold and whether the cache owes memory a writeback
    logic [7:0] resTag [16];
    logic [15:0] resValid;
    logic [15:0] resDirty;
    int readCount;
    int writeCount;
    logic memReqQ;

    logic validReq;
    logic completes;
    logic resident;
    logic victimDirty;
    logic [3:0] reqIndex;

    tbClock u_tbClock (
        .clock(clock)
    );

    memoryModel u_memoryModel (
        .clock(clock),
        .reset(reset),
        .memReq(memReq),
        .memCmd(memCmd),
        .memAck(memAck),
        .memRdata(memRdata)
    );

    dataCache u_dataCache (
        .clock(clock),
        .reset(reset),
        .cpuReq(cpuReq),
        .memAck(memAck),
        .memRdata(memRdata),
        .rdata(rdata),
        .stall(stall),
        .memReq(memReq),
        .memCmd(memCmd)
    );

    function automatic logic [7:0] patternByte(input logic [15:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
    endfunction

    function automatic logic [7:0] expectedByte(input logic [15:0] a);
        return written[a] ? shadow[a] : patternByte(a);
    endfunction

    function automatic logic [31:0] expectedWord(input logic [15:0] a);
        logic [31:0] w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = expectedByte({a[15:2], 2'(b)});
        end
        return w;
    endfunction

    function automatic dcachePkg::cacheLine expectedLine(input logic [11:0] blockAddr);
        dcachePkg::cacheLine line;
        for (int k = 0; k < 16; k++) begin
            line.bytes[k] = expectedByte({blockAddr, 4'(k)});
        end
        return line;
    endfunction

    // four tags over four sets so lines keep evicting each other
    function automatic logic [15:0] randomAddr();
        logic [31:0] r;
        r = $random(seed);
        return {r[1:0], 6'h2a, 2'b00, r[3:2], r[5:4], 2'b00};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // present one access and hold it until the cache takes it
    task automatic access(input logic isWrite, input logic [15:0] addr,
                          input logic [3:0] byteEnable, input logic [31:0] wdata);
        cpuReq.read = !isWrite;
        cpuReq.write = isWrite;
        cpuReq.addr = addr;
        cpuReq.byteEnable = byteEnable;
        cpuReq.wdata = wdata;
        started = 1'b1;
        do begin
            @(negedge clock);
        end while (!accepted);
    endtask

    assign validReq = cpuReq.read ^ cpuReq.write;
    assign completes = validReq && !stall;
    assign reqIndex = cpuReq.addr[7:4];
    assign resident = resValid[reqIndex] && (resTag[reqIndex] == cpuReq.addr[15:8]);
    assign victimDirty = resValid[reqIndex] && resDirty[reqIndex];

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            written <= '0;
            resValid <= '0;
            resDirty <= '0;
            readCount <= 0;
            writeCount <= 0;
            memReqQ <= 1'b0;
            accepted <= 1'b0;
        end else begin
            memReqQ <= memReq;
            accepted <= completes;
            if (completes) begin
                resValid[reqIndex] <= 1'b1;
                resTag[reqIndex] <= cpuReq.addr[15:8];
                readCount <= 0;
                writeCount <= 0;
                if (cpuReq.write) begin
                    resDirty[reqIndex] <= 1'b1;
                    for (int b = 0; b < 4; b++) begin
                        if (cpuReq.byteEnable[b]) begin
                            shadow[{cpuReq.addr[15:2], 2'(b)}] <= cpuReq.wdata[8*b +: 8];
                            written[{cpuReq.addr[15:2], 2'(b)}] <= 1'b1;
                        end
                    end
                end else if (!resident) begin
                    resDirty[reqIndex] <= 1'b0;
                end
            end else if (memReq && !memReqQ) begin
                if (memCmd.write) begin
                    writeCount <= writeCount + 1;
                end else begin
                    readCount <= readCount + 1;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            failRun($sformatf("timeout: no finish after %0d cycles", cycles));
        end
    end

    // quiet until the first access
    assert property (@(posedge clock) disable iff (!reset) !started |-> (!stall && !memReq))
        else failRun($sformatf("ERR stall got %h memReq got %h expected 0", stall, memReq));

    assert property (@(posedge clock) disable iff (!reset) (validReq && resident) |-> !stall)
        else failRun($sformatf("ERR stall got %h expected 0 at addr %h", stall, cpuReq.addr));

    // one fetch per miss and a writeback first only for a dirty victim
    assert property (@(posedge clock) disable iff (!reset)
        completes |-> readCount == (resident ? 0 : 1))
        else failRun($sformatf("ERR readCount got %h expected %h", readCount, !resident));

    assert property (@(posedge clock) disable iff (!reset)
        completes |-> writeCount == ((!resident && victimDirty) ? 1 : 0))
        else failRun($sformatf("ERR writeCount got %h expected %h", writeCount,
                               !resident && victimDirty));

    // a dirty victim goes back to memory before its replacement is fetched
    assert property (@(posedge clock) disable iff (!reset)
        ($rose(memReq) && !memCmd.write) |-> writeCount == (victimDirty ? 1 : 0))
        else failRun($sformatf("ERR writeCount got %h expected %h as the fetch began",
                               writeCount, victimDirty));

    assert property (@(posedge clock) disable iff (!reset)
        (memReq && !memCmd.write) |-> memCmd.blockAddr == cpuReq.addr[15:4])
        else failRun($sformatf("ERR memCmd.blockAddr got %h expected %h",
                               memCmd.blockAddr, cpuReq.addr[15:4]));

    assert property (@(posedge clock) disable iff (!reset)
        (memReq && memCmd.write) |-> memCmd.blockAddr == {resTag[reqIndex], reqIndex})
        else failRun($sformatf("ERR memCmd.blockAddr got %h expected %h",
                               memCmd.blockAddr, {resTag[reqIndex], reqIndex}));

    assert property (@(posedge clock) disable iff (!reset)
        (memReq && memCmd.write) |-> memCmd.line == expectedLine(memCmd.blockAddr))
        else failRun($sformatf("ERR memCmd.line got %h expected %h",
                               memCmd.line, expectedLine(memCmd.blockAddr)));

    assert property (@(posedge clock) disable iff (!reset)
        (completes && cpuReq.read) |-> rdata == expectedWord(cpuReq.addr))
        else failRun($sformatf("ERR rdata got %h expected %h at addr %h",
                               rdata, expectedWord(cpuReq.addr), cpuReq.addr));

    // four-phase rules at the memory port
    assert property (@(posedge clock) disable iff (!reset) $rose(memReq) |-> !memAck)
        else failRun($sformatf("ERR memAck got %h expected 0 as memReq rose", memAck));

    assert property (@(posedge clock) disable iff (!reset) $fell(memReq) |-> $past(memAck))
        else failRun("memReq fell before memory acknowledged");

    assert property (@(posedge clock) disable iff (!reset)
        (memReq && $past(memReq)) |-> $stable(memCmd))
        else failRun("memCmd changed while memReq was high");

    initial begin
        seed = 32'hb82c;
        started = 1'b0;
        cpuReq = '0;
        reset = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        // clean read miss then a hit in the same block
        access(1'b0, 16'h1230, 4'h0, 32'h0);
        access(1'b0, 16'h123c, 4'h0, 32'h0);
        // store hit with random byte enables and its read back
        access(1'b1, 16'h1234, 4'($random(seed)), $random(seed));
        access(1'b0, 16'h1234, 4'h0, 32'h0);
        // same set under a new tag evicts the dirty line
        access(1'b0, 16'h4530, 4'h0, 32'h0);
        for (int i = 0; i < numRandom; i++) begin
            access(1'($random(seed)), randomAddr(), 4'($random(seed)), $random(seed));
        end
        cpuReq = '0;
        repeat (4) @(negedge clock);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/memoryModel.sv
// backing memory with four-phase handshake, random ack delay and a line image
`default_nettype none

module memoryModel (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic memReq,
    input  wire dcachePkg::memCommand memCmd,
    output logic memAck,
    output dcachePkg::cacheLine memRdata
);

    integer seed = 32'hb82c;
    logic busy;
    logic [1:0] waitCycles;

    // lines never written back still hold the preload pattern
    logic [4095:0] touched;
    dcachePkg::cacheLine image [4096];

    function automatic logic [7:0] patternByte(input logic [15:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
    endfunction

    function automatic dcachePkg::cacheLine patternLine(input logic [11:0] blockAddr);
        dcachePkg::cacheLine line;
        for (int k = 0; k < 16; k++) begin
            line.bytes[k] = patternByte({blockAddr, 4'(k)});
        end
        return line;
    endfunction

    // responses change on the falling edge away from the cache's sampling edge
    always @(negedge clock or negedge reset) begin
        if (!reset) begin
            memAck <= 1'b0;
            busy <= 1'b0;
            waitCycles <= 2'd0;
            touched <= '0;
            memRdata <= '0;
        end else if (memAck) begin
            // close the handshake once the cache lets go
            if (!memReq) begin
                memAck <= 1'b0;
                busy <= 1'b0;
            end
        end else if (memReq) begin
            if (!busy) begin
                busy <= 1'b1;
                waitCycles <= 2'($unsigned($random(seed)));
            end else if (waitCycles != 2'd0) begin
                waitCycles <= waitCycles - 2'd1;
            end else begin
                memAck <= 1'b1;
                if (memCmd.write) begin
                    image[memCmd.blockAddr] <= memCmd.line;
                    touched[memCmd.blockAddr] <= 1'b1;
                end else if (touched[memCmd.blockAddr]) begin
                    memRdata <= image[memCmd.blockAddr];
                end else begin
                    memRdata <= patternLine(memCmd.blockAddr);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
// free-running testbench clock with a period of 4 time units
`default_nettype none

module tbClock (
    output logic clock
);

    // half period of 2
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dataCache.sv
// top level joining miss controller and storage array to pipeline and memory
`default_nettype none

module dataCache (
    input  wire logic clock,
    input  wire logic reset,
    input  wire dcachePkg::cpuRequest cpuReq,
    input  wire logic memAck,
    input  wire dcachePkg::cacheLine memRdata,
    output logic [dcachePkg::wordBytes*8-1:0] rdata,
    output logic stall,
    output logic memReq,
    output dcachePkg::memCommand memCmd
);

    // array status back to the controller
    logic hit;
    logic victimDirty;
    logic [dcachePkg::tagWidth-1:0] victimTag;
    dcachePkg::cacheLine readLine;

    // controller strobes into the array
    logic hitWrite;
    logic fillWrite;
    dcachePkg::cacheLine fillLine;

    dcacheController u_dcacheController (
        .clock(clock),
        .reset(reset),
        .request(cpuReq),
        .hit(hit),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .readLine(readLine),
        .memAck(memAck),
        .memRdata(memRdata),
        .stall(stall),
        .hitWrite(hitWrite),
        .fillWrite(fillWrite),
        .fillLine(fillLine),
        .rdata(rdata),
        .memReq(memReq),
        .memCmd(memCmd)
    );

    // array sees the held request address and store data directly
    dcacheArray u_dcacheArray (
        .clock(clock),
        .reset(reset),
        .addr(cpuReq.addr),
        .hitWrite(hitWrite),
        .fillWrite(fillWrite),
        .byteEnable(cpuReq.byteEnable),
        .wdata(cpuReq.wdata),
        .fillLine(fillLine),
        .hit(hit),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .readLine(readLine)
    );

endmodule

`default_nettype wire

// File: rtl/dcacheController.sv
// hit path, miss FSM with writeback, fetch and fill, four-phase memory handshake
`default_nettype none

module dcacheController (
    input  wire logic clock,
    input  wire logic reset,
    input  wire dcachePkg::cpuRequest request,
    input  wire logic hit,
    input  wire logic victimDirty,
    input  wire logic [dcachePkg::tagWidth-1:0] victimTag,
    input  wire dcachePkg::cacheLine readLine,
    input  wire logic memAck,
    input  wire dcachePkg::cacheLine memRdata,
    output logic stall,
    output logic hitWrite,
    output logic fillWrite,
    output dcachePkg::cacheLine fillLine,
    output logic [dcachePkg::wordBytes*8-1:0] rdata,
    output logic memReq,
    output dcachePkg::memCommand memCmd
);

    typedef enum logic [2:0] {
        idle,
        writeBack,
        writeBackRelease,
        fetch,
        fetchRelease,
        fill
    } stateType;

    stateType state;
    stateType nextState;

    logic validReq;
    logic isStore;
    logic [dcachePkg::indexWidth-1:0] index;
    logic [1:0] wordSel;

    // fetched block held until the fill cycle
    dcachePkg::cacheLine lineReg;

    // exactly one of read or write
    assign validReq = request.read ^ request.write;
    assign isStore = request.write && !request.read;
    assign index = request.addr[dcachePkg::offsetWidth +: dcachePkg::indexWidth];
    assign wordSel = request.addr[3:2];

    // read hit path with zero added latency
    assign rdata = readLine.words[wordSel];

    assign hitWrite = (state == idle) && isStore && hit;
    assign fillWrite = (state == fill);

    // stall on the miss cycle itself and then for the whole miss
    assign stall = (state != idle) || (validReq && !hit);

    assign memReq = (state == writeBack) || (state == fetch);

    // victim line goes out on writeback while read commands ignore the line field
    always_comb begin
        memCmd.write = (state == writeBack);
        memCmd.line = readLine;
        if (state == writeBack) begin
            memCmd.blockAddr = {victimTag, index};
        end else begin
            memCmd.blockAddr = request.addr[dcachePkg::addrWidth-1:dcachePkg::offsetWidth];
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (validReq && !hit) begin
                    nextState = victimDirty ? writeBack : fetch;
                end
            end
            writeBack: begin
                if (memAck) begin
                    nextState = writeBackRelease;
                end
            end
            writeBackRelease: begin
                // wait for memory to close the handshake
                if (!memAck) begin
                    nextState = fetch;
                end
            end
            fetch: begin
                if (memAck) begin
                    nextState = fetchRelease;
                end
            end
            fetchRelease: begin
                if (!memAck) begin
                    nextState = fill;
                end
            end
            fill: begin
                nextState = idle;
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // memRdata is only valid while memAck is high
    always_ff @(posedge clock) begin
        if ((state == fetch) && memAck) begin
            lineReg <= memRdata;
        end
    end

    // merge the enabled store bytes into the fetched block
    always_comb begin
        fillLine = lineReg;
        if (isStore) begin
            for (int b = 0; b < dcachePkg::wordBytes; b++) begin
                if (request.byteEnable[b]) begin
                    fillLine.bytes[wordSel * dcachePkg::wordBytes + b] =
                        request.wdata[8*b +: 8];
                end
            end
        end
    end

    // handshake rules seen at the memory port
    assert property (@(posedge clock) disable iff (!reset) $fell(memReq) |-> $past(memAck))
        else $error("memReq dropped before memAck");

    assert property (@(posedge clock) disable iff (!reset) $rose(memReq) |-> !memAck)
        else $error("memReq raised while memAck high");

    assert property (@(posedge clock) disable iff (!reset)
        (memReq && $past(memReq)) |-> $stable(memCmd))
        else $error("memCmd changed during a transaction");

endmodule

`default_nettype wire

// File: rtl/dcacheArray.sv
// direct-mapped tag, valid, dirty and data storage with hit detect and line update
`default_nettype none

module dcacheArray (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic [dcachePkg::addrWidth-1:0] addr,
    input  wire logic hitWrite,
    input  wire logic fillWrite,
    input  wire logic [dcachePkg::wordBytes-1:0] byteEnable,
    input  wire logic [dcachePkg::wordBytes*8-1:0] wdata,
    input  wire dcachePkg::cacheLine fillLine,
    output logic hit,
    output logic victimDirty,
    output logic [dcachePkg::tagWidth-1:0] victimTag,
    output dcachePkg::cacheLine readLine
);

    logic [dcachePkg::indexWidth-1:0] index;
    logic [dcachePkg::tagWidth-1:0] tag;
    logic [1:0] wordSel;

    // per-line state
    logic [dcachePkg::numLines-1:0] valid;
    logic [dcachePkg::numLines-1:0] dirty;
    logic [dcachePkg::tagWidth-1:0] tags [dcachePkg::numLines];
    dcachePkg::cacheLine lines [dcachePkg::numLines];

    // stored line with the store bytes patched in
    dcachePkg::cacheLine hitLine;

    assign index = addr[dcachePkg::offsetWidth +: dcachePkg::indexWidth];
    assign tag = addr[dcachePkg::addrWidth-1 -: dcachePkg::tagWidth];
    assign wordSel = addr[3:2];

    // lookup is purely combinational from the address
    assign readLine = lines[index];
    assign victimTag = tags[index];
    assign hit = valid[index] && (tags[index] == tag);
    assign victimDirty = valid[index] && dirty[index];

    always_comb begin
        hitLine = readLine;
        for (int b = 0; b < dcachePkg::wordBytes; b++) begin
            if (byteEnable[b]) begin
                hitLine.bytes[wordSel * dcachePkg::wordBytes + b] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (fillWrite) begin
            valid[index] <= 1'b1;
            // a store that missed sets dirty on its completing hit write
            // one cycle after the fill
            dirty[index] <= 1'b0;
        end else if (hitWrite) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fillWrite) begin
            tags[index] <= tag;
            lines[index] <= fillLine;
        end else if (hitWrite) begin
            lines[index] <= hitLine;
        end
    end

    // controller never fills and stores in the same cycle
    assert property (@(posedge clock) disable iff (!reset) !(hitWrite && fillWrite))
        else $error("hitWrite and fillWrite high together");

endmodule

`default_nettype wire

// File: rtl/dcachePkg.sv
// cache geometry constants, pipeline request and memory command structs, cache line union
`default_nettype none

package dcachePkg;

    // byte address split as tag | index | offset
    localparam int addrWidth = 16;
    localparam int wordBytes = 4;
    localparam int lineWords = 4;
    localparam int lineBytes = 16;
    localparam int offsetWidth = 4;
    localparam int indexWidth = 4;
    localparam int numLines = 16;
    localparam int tagWidth = 8;
    localparam int blockAddrWidth = 12;

    // one line, seen either as words or as bytes
    typedef union packed {
        logic [lineWords-1:0][wordBytes*8-1:0] words;
        logic [lineBytes-1:0][7:0] bytes;
    } cacheLine;

    // pipeline access, held unchanged while stalled
    typedef struct packed {
        logic read;
        logic write;
        logic [addrWidth-1:0] addr;
        logic [wordBytes-1:0] byteEnable;
        logic [wordBytes*8-1:0] wdata;
    } cpuRequest;

    // one memory transaction, a whole line either way
    typedef struct packed {
        logic write;
        logic [blockAddrWidth-1:0] blockAddr;
        cacheLine line;
    } memCommand;

endpackage

`default_nettype wire
